// ==== dcache_hit_macros.svh ====
`ifndef DCACHE_HIT_MACROS_SVH
`define DCACHE_HIT_MACROS_SVH

// data word width
`define DCACHE_XLEN       32

// physical address width
`define DCACHE_PLEN       32

// one cache line
`define DCACHE_LINE_BITS  128

// associativity
`define DCACHE_WAYS       2

// sets per way
`define DCACHE_SETS       64

`endif

// ==== dcache_cfg_pkg.sv ====
`include "dcache_hit_macros.svh"

package dcache_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // derived geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int WORDS_PER_LINE = `DCACHE_LINE_BITS / `DCACHE_XLEN;

  // word select within a line
  localparam int OFFS_BITS      = $clog2(WORDS_PER_LINE);

  // byte address within a line
  localparam int BLK_OFFS_BITS  = $clog2(`DCACHE_LINE_BITS / 8);

  localparam int IDX_BITS       = $clog2(`DCACHE_SETS);
  localparam int TAG_BITS       = `DCACHE_PLEN - IDX_BITS - BLK_OFFS_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // address and data fields
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`DCACHE_PLEN-1:0]           adr_t;
  typedef logic [`DCACHE_XLEN-1:0]           word_t;
  typedef logic [`DCACHE_XLEN/8-1:0]         be_t;
  typedef logic [`DCACHE_LINE_BITS-1:0]      line_t;
  typedef logic [`DCACHE_LINE_BITS/8-1:0]    line_be_t;

  typedef logic [IDX_BITS-1:0]               idx_t;
  typedef logic [OFFS_BITS-1:0]              offs_t;
  typedef logic [TAG_BITS-1:0]               tag_t;

  // one bit per way, one-hot
  typedef logic [`DCACHE_WAYS-1:0]           ways_t;

endpackage

// ==== dcache_bus_pkg.sv ====
package dcache_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////////////////////

  // load/store request from the core
  typedef struct packed {
    logic                  we;
    dcache_cfg_pkg::adr_t  adr;
    dcache_cfg_pkg::be_t   be;
    dcache_cfg_pkg::word_t d;
    logic                  pma_exc;
    logic                  pmp_exc;
    logic                  misaligned;
  } core_req_t;

  typedef struct packed {
    dcache_cfg_pkg::word_t q;
    logic                  err;
    logic                  misaligned;
  } core_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // tag and data memories
  ////////////////////////////////////////////////////////////////////////////

  // lookup result for the address on req_i
  typedef struct packed {
    logic                  hit;
    dcache_cfg_pkg::ways_t ways_hit;
    logic                  way_dirty;
    dcache_cfg_pkg::line_t line;
  } lookup_t;

  typedef struct packed {
    dcache_cfg_pkg::tag_t  tag;
    dcache_cfg_pkg::idx_t  idx;
  } mem_adr_t;

  // pending store, byte enables already line aligned
  typedef struct packed {
    dcache_cfg_pkg::idx_t     idx;
    dcache_cfg_pkg::offs_t    offs;
    dcache_cfg_pkg::word_t    data;
    dcache_cfg_pkg::line_be_t line_be;
    dcache_cfg_pkg::ways_t    ways;
  } wbuf_entry_t;

  ////////////////////////////////////////////////////////////////////////////
  // bus interface unit
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BIU_NOP      = 2'd0,
    BIU_READWAY  = 2'd1,
    BIU_WRITEWAY = 2'd2
  } biu_cmd_e;

  // one returned word of a line fill
  typedef struct packed {
    logic                  ack;
    logic                  err;
    dcache_cfg_pkg::word_t q;
    dcache_cfg_pkg::adr_t  adr;
  } biu_rsp_t;

endpackage

// ==== dcache_req_decode.sv ====
module dcache_req_decode (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       req_valid_i,
  input  dcache_bus_pkg::core_req_t  req_i,
  input  logic                       flush_i,

  output logic                       valid_req_o,
  output dcache_bus_pkg::mem_adr_t   mem_adr_o,
  output dcache_cfg_pkg::offs_t      offs_o,
  output dcache_bus_pkg::core_rsp_t  exc_o
);

  logic access_exc;
  logic any_exc;
  logic req_live;

  ////////////////////////////////////////////////////////////////////////////
  // qualification
  ////////////////////////////////////////////////////////////////////////////

  assign access_exc = req_i.pma_exc | req_i.pmp_exc;
  assign any_exc    = access_exc | req_i.misaligned;

  // request present and not cancelled by the pipeline
  assign req_live    = req_valid_i & ~flush_i;
  assign valid_req_o = req_live & ~any_exc;

  ////////////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////////////

  assign mem_adr_o.idx = req_i.adr[dcache_cfg_pkg::BLK_OFFS_BITS +: dcache_cfg_pkg::IDX_BITS];
  assign mem_adr_o.tag = req_i.adr[$bits(dcache_cfg_pkg::adr_t)-1 -: dcache_cfg_pkg::TAG_BITS];

  // word within the line, byte bits dropped
  assign offs_o = req_i.adr[dcache_cfg_pkg::BLK_OFFS_BITS-1 -: dcache_cfg_pkg::OFFS_BITS];

  ////////////////////////////////////////////////////////////////////////////
  // exception response
  ////////////////////////////////////////////////////////////////////////////

  // no data comes back with an exception, only the flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_o <= '0;
    end else begin
      exc_o.q          <= '0;
      exc_o.err        <= req_live & access_exc;
      exc_o.misaligned <= req_live & req_i.misaligned;
    end
  end

endmodule

// ==== dcache_miss_fsm.sv ====
module dcache_miss_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       valid_req_i,
  input  logic                       wr_i,
  input  dcache_bus_pkg::mem_adr_t   mem_adr_i,
  input  dcache_cfg_pkg::offs_t      offs_i,
  input  dcache_bus_pkg::lookup_t    lookup_i,
  input  dcache_cfg_pkg::ways_t      fill_way_i,
  input  logic                       wbuf_busy_i,
  input  logic                       biu_cmd_ack_i,
  input  dcache_bus_pkg::biu_rsp_t   biu_rsp_i,
  input  logic                       flush_i,

  output dcache_bus_pkg::biu_cmd_e   biu_cmd_o,
  output logic                       filling_o,
  output dcache_cfg_pkg::ways_t      fill_way_o,
  output logic                       evict_read_o,
  output logic                       armed_o,
  output logic                       stall_o,
  output logic                       latchmem_o
);

  localparam int PLEN     = $bits(dcache_cfg_pkg::adr_t);
  localparam int WORD_LSB = dcache_cfg_pkg::BLK_OFFS_BITS - dcache_cfg_pkg::OFFS_BITS;

  typedef enum logic [2:0] {
    ARMED    = 3'd0,
    READ     = 3'd1,
    EVICT    = 3'd2,
    RECOVER0 = 3'd3,
    RECOVER1 = 3'd4
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  dcache_bus_pkg::biu_cmd_e cmd_d;
  dcache_cfg_pkg::ways_t    fill_way_d;
  logic                     evict_read_d;
  logic                     word_match;
  logic                     rsp_done;

  // returned word belongs to the waiting load
  assign word_match = biu_rsp_i.ack &
                      (biu_rsp_i.adr[PLEN-1:WORD_LSB] == {mem_adr_i.tag, mem_adr_i.idx, offs_i});

  // stores wait for the refill and then hit in the cache
  assign rsp_done = valid_req_i & ((word_match & ~wr_i) | biu_rsp_i.err);

  ////////////////////////////////////////////////////////////////////////////
  // next state, command, stall
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    cmd_d        = biu_cmd_o;
    fill_way_d   = fill_way_o;
    evict_read_d = 1'b0;
    stall_o      = 1'b1;
    latchmem_o   = 1'b0;

    case (state_q)
      ARMED: begin
        stall_o    = valid_req_i & (~lookup_i.hit | (wr_i & wbuf_busy_i));
        latchmem_o = ~stall_o;

        // miss, only once the write buffer has drained
        if (valid_req_i && !lookup_i.hit && !wbuf_busy_i) begin
          fill_way_d = fill_way_i;
          cmd_d      = dcache_bus_pkg::BIU_READWAY;
          if (lookup_i.way_dirty) begin
            // old line is read out for the evict buffer
            state_d      = EVICT;
            evict_read_d = 1'b1;
          end else begin
            state_d = READ;
          end
        end
      end

      READ, EVICT: begin
        stall_o    = ~flush_i & ~rsp_done;
        latchmem_o = ~stall_o;

        if (biu_cmd_ack_i || biu_rsp_i.err) begin
          state_d = RECOVER0;
          // write back the victim once the new line is in
          if (state_q == EVICT && biu_cmd_ack_i) begin
            cmd_d = dcache_bus_pkg::BIU_WRITEWAY;
          end else begin
            cmd_d = dcache_bus_pkg::BIU_NOP;
          end
        end
      end

      // index back on the memories
      RECOVER0: begin
        state_d = RECOVER1;
        cmd_d   = dcache_bus_pkg::BIU_NOP;
      end

      // latch the refreshed tag and data outputs
      RECOVER1: begin
        state_d    = ARMED;
        latchmem_o = 1'b1;
      end

      default: begin
        state_d = ARMED;
        cmd_d   = dcache_bus_pkg::BIU_NOP;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ARMED;
      biu_cmd_o    <= dcache_bus_pkg::BIU_NOP;
      fill_way_o   <= '0;
      evict_read_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      biu_cmd_o    <= cmd_d;
      fill_way_o   <= fill_way_d;
      evict_read_o <= evict_read_d;
    end
  end

  assign armed_o   = (state_q == ARMED);
  assign filling_o = (state_q == READ) || (state_q == EVICT);

endmodule

// ==== dcache_result.sv ====
module dcache_result (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        valid_req_i,
  input  logic                        wr_i,
  input  dcache_bus_pkg::mem_adr_t    mem_adr_i,
  input  dcache_cfg_pkg::offs_t       offs_i,
  input  dcache_cfg_pkg::be_t         be_i,
  input  dcache_cfg_pkg::word_t       d_i,
  input  dcache_bus_pkg::lookup_t     lookup_i,
  input  dcache_bus_pkg::biu_rsp_t    biu_rsp_i,
  input  logic                        armed_i,
  input  logic                        filling_i,
  input  dcache_bus_pkg::core_rsp_t   exc_i,
  input  logic                        flush_i,
  input  logic                        wbuf_ready_i,

  output logic                        wbuf_valid_o,
  output dcache_bus_pkg::wbuf_entry_t wbuf_o,
  output logic                        wbuf_busy_o,
  output logic                        rsp_valid_o,
  output dcache_bus_pkg::core_rsp_t   rsp_o
);

  localparam int PLEN     = $bits(dcache_cfg_pkg::adr_t);
  localparam int XLEN     = $bits(dcache_cfg_pkg::word_t);
  localparam int WORD_LSB = dcache_cfg_pkg::BLK_OFFS_BITS - dcache_cfg_pkg::OFFS_BITS;

  logic                  word_match;
  logic                  hit_ack;
  logic                  fill_ack;
  logic                  fill_err;
  logic                  wr_hit;
  logic                  bypass;
  dcache_cfg_pkg::line_t wbuf_line;
  dcache_cfg_pkg::line_t line_merged;
  dcache_cfg_pkg::word_t cache_q;
  logic                  rsp_valid_q;
  logic                  rsp_err_q;
  dcache_cfg_pkg::word_t rsp_q;
  logic                  armed_q;

  ////////////////////////////////////////////////////////////////////////////
  // acknowledge
  ////////////////////////////////////////////////////////////////////////////

  assign wbuf_busy_o = wbuf_valid_o & ~wbuf_ready_i;

  assign word_match = biu_rsp_i.ack &
                      (biu_rsp_i.adr[PLEN-1:WORD_LSB] == {mem_adr_i.tag, mem_adr_i.idx, offs_i});

  // a store hit waits while the buffer is held
  assign hit_ack  = armed_i & valid_req_i & lookup_i.hit & ~(wr_i & wbuf_busy_o);
  assign fill_ack = filling_i & valid_req_i & ~wr_i & word_match;
  assign fill_err = filling_i & valid_req_i & biu_rsp_i.err;
  assign wr_hit   = hit_ack & wr_i;

  ////////////////////////////////////////////////////////////////////////////
  // write buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wbuf_valid_o <= 1'b0;
    end else if (flush_i) begin
      wbuf_valid_o <= 1'b0;
    end else if (wr_hit) begin
      wbuf_valid_o <= 1'b1;
    end else if (wbuf_ready_i) begin
      wbuf_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hit) begin
      wbuf_o.idx     <= mem_adr_i.idx;
      wbuf_o.offs    <= offs_i;
      wbuf_o.data    <= d_i;
      wbuf_o.line_be <= dcache_cfg_pkg::line_be_t'(be_i) << (offs_i * (XLEN / 8));
      wbuf_o.ways    <= lookup_i.ways_hit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bypass and word select
  ////////////////////////////////////////////////////////////////////////////

  // memory line is stale while the store sits in the buffer
  assign bypass    = wbuf_valid_o & (wbuf_o.idx == mem_adr_i.idx) &
                     (wbuf_o.ways == lookup_i.ways_hit);
  assign wbuf_line = {dcache_cfg_pkg::WORDS_PER_LINE{wbuf_o.data}};

  always_comb begin
    line_merged = lookup_i.line;
    for (int i = 0; i < $bits(dcache_cfg_pkg::line_be_t); i++) begin
      if (bypass && wbuf_o.line_be[i]) begin
        line_merged[i*8 +: 8] = wbuf_line[i*8 +: 8];
      end
    end
  end

  assign cache_q = line_merged[offs_i * XLEN +: XLEN];

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
      armed_q     <= 1'b1;
    end else begin
      rsp_valid_q <= hit_ack | fill_ack | fill_err;
      rsp_err_q   <= fill_err;
      armed_q     <= armed_i;
    end
  end

  // bus word during a fill
  always_ff @(posedge clk_i) begin
    rsp_q <= filling_i ? biu_rsp_i.q : cache_q;
  end

  // exceptions count only for requests seen while armed
  assign rsp_valid_o = rsp_valid_q | (armed_q & (exc_i.err | exc_i.misaligned));
  assign rsp_o       = '{q:          rsp_q,
                         err:        rsp_err_q | (armed_q & exc_i.err),
                         misaligned: armed_q & exc_i.misaligned};

endmodule

// ==== dcache_hit.sv ====
module dcache_hit (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,

  // core request
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  dcache_bus_pkg::core_req_t   req_i,

  // tag and data memories
  input  dcache_bus_pkg::lookup_t     lookup_i,
  input  dcache_cfg_pkg::ways_t       fill_way_i,
  output dcache_bus_pkg::mem_adr_t    mem_adr_o,
  output logic                        latchmem_o,

  // write buffer
  output logic                        wbuf_valid_o,
  input  logic                        wbuf_ready_i,
  output dcache_bus_pkg::wbuf_entry_t wbuf_o,

  // bus interface
  output dcache_bus_pkg::biu_cmd_e    biu_cmd_o,
  input  logic                        biu_cmd_ack_i,
  input  dcache_bus_pkg::biu_rsp_t    biu_rsp_i,
  output logic                        filling_o,
  output dcache_cfg_pkg::ways_t       fill_way_o,
  output logic                        evict_read_o,

  // core response
  output logic                        rsp_valid_o,
  output dcache_bus_pkg::core_rsp_t   rsp_o
);

  logic                      valid_req;
  dcache_cfg_pkg::offs_t     offs;
  dcache_bus_pkg::core_rsp_t exc;
  logic                      armed;
  logic                      stall;
  logic                      wbuf_busy;

  dcache_req_decode i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .flush_i     (flush_i),
    .valid_req_o (valid_req),
    .mem_adr_o   (mem_adr_o),
    .offs_o      (offs),
    .exc_o       (exc)
  );

  dcache_miss_fsm i_miss_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_req_i   (valid_req),
    .wr_i          (req_i.we),
    .mem_adr_i     (mem_adr_o),
    .offs_i        (offs),
    .lookup_i      (lookup_i),
    .fill_way_i    (fill_way_i),
    .wbuf_busy_i   (wbuf_busy),
    .biu_cmd_ack_i (biu_cmd_ack_i),
    .biu_rsp_i     (biu_rsp_i),
    .flush_i       (flush_i),
    .biu_cmd_o     (biu_cmd_o),
    .filling_o     (filling_o),
    .fill_way_o    (fill_way_o),
    .evict_read_o  (evict_read_o),
    .armed_o       (armed),
    .stall_o       (stall),
    .latchmem_o    (latchmem_o)
  );

  dcache_result i_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_req_i  (valid_req),
    .wr_i         (req_i.we),
    .mem_adr_i    (mem_adr_o),
    .offs_i       (offs),
    .be_i         (req_i.be),
    .d_i          (req_i.d),
    .lookup_i     (lookup_i),
    .biu_rsp_i    (biu_rsp_i),
    .armed_i      (armed),
    .filling_i    (filling_o),
    .exc_i        (exc),
    .flush_i      (flush_i),
    .wbuf_ready_i (wbuf_ready_i),
    .wbuf_valid_o (wbuf_valid_o),
    .wbuf_o       (wbuf_o),
    .wbuf_busy_o  (wbuf_busy),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  assign req_ready_o = ~stall;

endmodule

// ==== dcache_hit_props.sv ====
module dcache_hit_props (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        req_valid_i,
  input  logic                        req_ready_o,
  input  dcache_bus_pkg::core_req_t   req_i,
  input  logic                        wbuf_valid_o,
  input  logic                        wbuf_ready_i,
  input  dcache_bus_pkg::wbuf_entry_t wbuf_o,
  input  dcache_bus_pkg::biu_cmd_e    biu_cmd_o,
  input  logic                        armed_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // core keeps a stalled request steady
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !req_ready_o && !flush_i) |=> (req_valid_i && $stable(req_i)))
    else $error("request changed while stalled");

  // pending store stays put until accepted
  wbuf_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wbuf_valid_o && !wbuf_ready_i && !flush_i) |=> (wbuf_valid_o && $stable(wbuf_o)))
    else $error("write buffer entry changed before accept");

  // no bus traffic when nothing is asked
  cmd_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (armed_i && !req_valid_i) |-> (biu_cmd_o == dcache_bus_pkg::BIU_NOP))
    else $error("bus command issued while idle");

endmodule

// ==== tb_dcache_hit.sv ====
`include "dcache_hit_macros.svh"

module tb_dcache_hit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 400;
  localparam int SETS           = `DCACHE_SETS;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        flush_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  dcache_bus_pkg::core_req_t   req_i;
  dcache_bus_pkg::lookup_t     lookup_i;
  dcache_cfg_pkg::ways_t       fill_way_i;
  dcache_bus_pkg::mem_adr_t    mem_adr_o;
  logic                        latchmem_o;
  logic                        wbuf_valid_o;
  logic                        wbuf_ready_i;
  dcache_bus_pkg::wbuf_entry_t wbuf_o;
  dcache_bus_pkg::biu_cmd_e    biu_cmd_o;
  logic                        biu_cmd_ack_i;
  dcache_bus_pkg::biu_rsp_t    biu_rsp_i;
  logic                        filling_o;
  dcache_cfg_pkg::ways_t       fill_way_o;
  logic                        evict_read_o;
  logic                        rsp_valid_o;
  dcache_bus_pkg::core_rsp_t   rsp_o;

  // cache model, 64 sets by 2 ways
  dcache_cfg_pkg::tag_t  tags  [SETS][2];
  dcache_cfg_pkg::line_t lines [SETS][2];
  logic                  vld   [SETS][2];
  logic                  dirty [SETS][2];

  integer seed;
  int     errors;
  int     checks;
  int     cycles;

  dcache_hit i_dut (.*);

  bind dcache_hit dcache_hit_props i_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .wbuf_valid_o (wbuf_valid_o),
    .wbuf_ready_i (wbuf_ready_i),
    .wbuf_o       (wbuf_o),
    .biu_cmd_o    (biu_cmd_o),
    .armed_i      (armed)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // cache model
  ////////////////////////////////////////////////////////////////////////////

  // victim is the first invalid way, else way 0
  always_comb begin
    logic [5:0] s;
    int         v;
    s        = req_i.adr[9:4];
    lookup_i = '0;
    for (int w = 0; w < 2; w++) begin
      if (vld[s][w] && tags[s][w] == req_i.adr[31:10]) begin
        lookup_i.hit         = 1'b1;
        lookup_i.ways_hit[w] = 1'b1;
        lookup_i.line        = lines[s][w];
      end
    end
    v                  = (vld[s][0] && !vld[s][1]) ? 1 : 0;
    fill_way_i         = 2'b01 << v;
    lookup_i.way_dirty = vld[s][v] & dirty[s][v];
  end

  // accepted store lands in the line and marks it dirty
  always @(posedge clk_i) begin
    if (rst_ni && wbuf_valid_o && wbuf_ready_i) begin
      for (int w = 0; w < 2; w++) begin
        if (wbuf_o.ways[w]) begin
          for (int b = 0; b < 16; b++) begin
            if (wbuf_o.line_be[b]) begin
              lines[wbuf_o.idx][w][b*8 +: 8] <= wbuf_o.data[(b % 4)*8 +: 8];
            end
          end
          dirty[wbuf_o.idx][w] <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic dcache_cfg_pkg::adr_t make_adr(input logic [21:0] tag,
                                                    input logic [5:0] idx,
                                                    input logic [1:0] offs);
    return {tag, idx, offs, 2'b00};
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] d,
                                             input logic [3:0] be);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        r[b*8 +: 8] = d[b*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    checks++;
    assert (expected === actual)
      else begin
        errors++;
        $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      end
  endtask

  // lands one time unit after the rising edge
  task automatic tick;
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_req(input logic we, input dcache_cfg_pkg::adr_t adr,
                           input logic [3:0] be, input logic [31:0] d);
    req_i       = '0;
    req_i.we    = we;
    req_i.adr   = adr;
    req_i.be    = be;
    req_i.d     = d;
    req_valid_i = 1'b1;
  endtask

  task automatic wait_ready;
    do begin
      tick;
    end while (!req_ready_o);
    #9;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_hit_test;
    dcache_cfg_pkg::adr_t adr;
    for (int i = 0; i < 3; i++) begin
      adr = make_adr(tags[3+i][i%2], 6'(3+i), 2'(i+1));
      drive_req(1'b0, adr, 4'hf, '0);
      tick;
      check_val("read_hit valid", 1, rsp_valid_o);
      check_val("read_hit data", lines[3+i][i%2][(i+1)*32 +: 32], rsp_o.q);
      check_val("read_hit mem adr", {tags[3+i][i%2], 6'(3+i)}, mem_adr_o);
      check_val("read_hit latch", 1, latchmem_o);
      #9;
    end
    req_valid_i = 1'b0;
    tick;
    check_val("read_hit valid drop", 0, rsp_valid_o);
    #9;
  endtask

  task automatic write_backpressure_test;
    logic [31:0] d1;
    logic [31:0] d2;
    d1           = $random(seed);
    d2           = $random(seed);
    wbuf_ready_i = 1'b0;
    drive_req(1'b1, make_adr(tags[7][1], 6'd7, 2'd1), 4'b0011, d1);
    tick;
    check_val("write wbuf valid", 1, wbuf_valid_o);
    check_val("write wbuf idx", 7, wbuf_o.idx);
    check_val("write wbuf offs", 1, wbuf_o.offs);
    check_val("write wbuf data", d1, wbuf_o.data);
    check_val("write wbuf be", 16'h0030, wbuf_o.line_be);
    check_val("write wbuf ways", 2'b10, wbuf_o.ways);
    #9;
    drive_req(1'b1, make_adr(tags[8][0], 6'd8, 2'd3), 4'hf, d2);
    repeat (3) begin
      tick;
      check_val("write stall ready", 0, req_ready_o);
      check_val("write held data", d1, wbuf_o.data);
    end
    #9;
    wbuf_ready_i = 1'b1;
    tick;
    check_val("write second data", d2, wbuf_o.data);
    check_val("write second be", 16'hf000, wbuf_o.line_be);
    #9;
    req_valid_i = 1'b0;
    tick;
    check_val("write drained", 0, wbuf_valid_o);
    #9;
  endtask

  task automatic bypass_test;
    logic [31:0] d;
    logic [31:0] expected;
    d            = $random(seed);
    expected     = merge_word(lines[12][0][31:0], d, 4'b0101);
    wbuf_ready_i = 1'b0;
    drive_req(1'b1, make_adr(tags[12][0], 6'd12, 2'd0), 4'b0101, d);
    tick;
    #9;
    drive_req(1'b0, make_adr(tags[12][0], 6'd12, 2'd0), 4'hf, '0);
    tick;
    check_val("bypass valid", 1, rsp_valid_o);
    check_val("bypass data", expected, rsp_o.q);
    #9;
    req_valid_i  = 1'b0;
    wbuf_ready_i = 1'b1;
    tick;
    #9;
  endtask

  // one line fill, optionally with a dirty victim
  task automatic miss_test(input string name, input logic [5:0] idx, input logic [21:0] tag,
                           input logic [1:0] offs, input logic bus_err, input logic evict);
    logic [31:0]           words [4];
    dcache_cfg_pkg::ways_t way;
    for (int k = 0; k < 4; k++) begin
      words[k] = $random(seed);
    end
    drive_req(1'b0, make_adr(tag, idx, offs), 4'hf, '0);
    tick;
    way = fill_way_i;
    check_val({name, " cmd"}, dcache_bus_pkg::BIU_READWAY, biu_cmd_o);
    check_val({name, " filling"}, 1, filling_o);
    check_val({name, " fill way"}, way, fill_way_o);
    check_val({name, " evict read"}, evict, evict_read_o);
    check_val({name, " stall"}, 0, req_ready_o);
    check_val({name, " no latch"}, 0, latchmem_o);
    #9;
    if (bus_err) begin
      biu_rsp_i.err = 1'b1;
      tick;
      check_val({name, " err valid"}, 1, rsp_valid_o);
      check_val({name, " err flag"}, 1, rsp_o.err);
      #9;
      biu_rsp_i   = '0;
      req_valid_i = 1'b0;
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (k > offs) begin
          req_valid_i = 1'b0;
        end
        biu_rsp_i     = '{ack: 1'b1, err: 1'b0, q: words[k], adr: make_adr(tag, idx, 2'(k))};
        biu_cmd_ack_i = (k == 3);
        tick;
        if (k == 0) begin
          check_val({name, " evict drop"}, 0, evict_read_o);
        end
        if (k == offs) begin
          check_val({name, " valid"}, 1, rsp_valid_o);
          check_val({name, " data"}, words[k], rsp_o.q);
          check_val({name, " no err"}, 0, rsp_o.err);
        end
        #9;
      end
      check_val({name, " write back"}, evict ? dcache_bus_pkg::BIU_WRITEWAY
                                             : dcache_bus_pkg::BIU_NOP, biu_cmd_o);
      req_valid_i   = 1'b0;
      biu_rsp_i     = '0;
      biu_cmd_ack_i = 1'b0;
      for (int w = 0; w < 2; w++) begin
        if (way[w]) begin
          tags[idx][w]  <= tag;
          lines[idx][w] <= {words[3], words[2], words[1], words[0]};
          vld[idx][w]   <= 1'b1;
          dirty[idx][w] <= 1'b0;
        end
      end
    end
    wait_ready;
    check_val({name, " cmd idle"}, dcache_bus_pkg::BIU_NOP, biu_cmd_o);
    if (!bus_err) begin
      drive_req(1'b0, make_adr(tag, idx, offs ^ 2'd1), 4'hf, '0);
      tick;
      check_val({name, " rehit valid"}, 1, rsp_valid_o);
      check_val({name, " rehit data"}, words[offs ^ 2'd1], rsp_o.q);
      #9;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic dirty_miss_test;
    drive_req(1'b1, make_adr(tags[9][0], 6'd9, 2'd1), 4'hf, $random(seed));
    tick;
    #9;
    req_valid_i = 1'b0;
    tick;
    #9;
    miss_test("dirty_miss", 6'd9, 22'h155, 2'd3, 1'b0, 1'b1);
  endtask

  task automatic exception_test;
    drive_req(1'b1, make_adr(tags[2][0], 6'd2, 2'd0), 4'hf, 32'h1234);
    req_i.pma_exc = 1'b1;
    tick;
    check_val("pma valid", 1, rsp_valid_o);
    check_val("pma err", 1, rsp_o.err);
    check_val("pma misaligned", 0, rsp_o.misaligned);
    check_val("pma no wbuf", 0, wbuf_valid_o);
    #9;
    drive_req(1'b0, make_adr(22'h2aa, 6'd20, 2'd1), 4'hf, '0);
    req_i.misaligned = 1'b1;
    tick;
    check_val("misaligned valid", 1, rsp_valid_o);
    check_val("misaligned flag", 1, rsp_o.misaligned);
    check_val("misaligned err", 0, rsp_o.err);
    check_val("misaligned cmd", dcache_bus_pkg::BIU_NOP, biu_cmd_o);
    #9;
    drive_req(1'b1, make_adr(tags[2][0], 6'd2, 2'd0), 4'hf, 32'h5678);
    flush_i = 1'b1;
    tick;
    check_val("flush no wbuf", 0, wbuf_valid_o);
    check_val("flush no rsp", 0, rsp_valid_o);
    #9;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    tick;
    check_val("flush cmd", dcache_bus_pkg::BIU_NOP, biu_cmd_o);
    #9;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 31;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    wbuf_ready_i  = 1'b1;
    biu_cmd_ack_i = 1'b0;
    biu_rsp_i     = '0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < 2; w++) begin
        tags[s][w]  <= 22'(w == 0 ? 'h100 + s : 'h200 + s);
        lines[s][w] <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        vld[s][w]   <= !(s == 5 && w == 1);
        dirty[s][w] <= 1'b0;
      end
    end
    repeat (5) @(posedge clk_i);
    #10;
    check_val("reset rsp valid", 0, rsp_valid_o);
    check_val("reset wbuf valid", 0, wbuf_valid_o);
    check_val("reset filling", 0, filling_o);
    check_val("reset evict", 0, evict_read_o);
    check_val("reset cmd", dcache_bus_pkg::BIU_NOP, biu_cmd_o);
    check_val("reset ready", 1, req_ready_o);
    rst_ni = 1'b1;

    read_hit_test;
    write_backpressure_test;
    bypass_test;
    miss_test("err_miss", 6'd5, 22'h3a5, 2'd2, 1'b1, 1'b0);
    miss_test("clean_miss", 6'd5, 22'h3a5, 2'd2, 1'b0, 1'b0);
    dirty_miss_test;
    exception_test;

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== dcache_hit.f ====
+incdir+.
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
dcache_req_decode.sv
dcache_miss_fsm.sv
dcache_result.sv
dcache_hit.sv
dcache_hit_props.sv
tb_dcache_hit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache_hit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_dcache_hit \
  -f dcache_hit.f \
  -o sim_dcache_hit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache_hit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
exit 1
